// File: source/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data word width
`define CORE_XLEN 32

// Bit counter width for a full-word pass
`define CORE_CNT_W 5

// Register file depth
`define CORE_NREGS 32

// First fetch address
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: source/core_pkg.sv
package core_pkg;

   // Instruction phase
   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      MEM,
      WBACK
   } core_state_e;

   // Decoded instruction class
   typedef enum logic [2:0] {
      OPC_ALU_REG,
      OPC_ALU_IMM,
      OPC_LUI,
      OPC_LOAD,
      OPC_STORE,
      OPC_BRANCH,
      OPC_NOP
   } core_opc_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } core_aluop_e;

endpackage

// File: source/core_state.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_state
   import core_pkg::*;
   (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_ibus_ack,
   input  logic                   i_dbus_ack,
   input  core_opc_e              i_opc,
   output core_state_e            o_phase,
   output logic [`CORE_CNT_W-1:0] o_cnt,
   output logic                   o_cnt_en,
   output logic                   o_pc_en,
   output logic                   o_rd_en,
   output logic                   o_ibus_cyc,
   output logic                   o_dbus_cyc
   );

   core_state_e            phase;
   core_state_e            phase_next;
   logic [`CORE_CNT_W-1:0] cnt;
   logic                   cnt_last;
   logic                   mem_op;
   logic                   fetch_done;
   logic                   mem_done;

   assign cnt_last   = &cnt;
   assign mem_op     = (i_opc == OPC_LOAD) || (i_opc == OPC_STORE);
   assign fetch_done = o_ibus_cyc && i_ibus_ack;
   assign mem_done   = o_dbus_cyc && i_dbus_ack;

   always_comb begin
      case (phase)
         FETCH:   phase_next = fetch_done ? EXEC : FETCH;
         EXEC:    phase_next = !cnt_last ? EXEC : (mem_op ? MEM : FETCH);
         MEM:     phase_next = !mem_done ? MEM : ((i_opc == OPC_LOAD) ? WBACK : FETCH);
         default: phase_next = cnt_last ? FETCH : WBACK;
      endcase
   end

   // Bus strobes follow the next phase
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         phase      <= FETCH;
         cnt        <= '0;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         phase      <= phase_next;
         o_ibus_cyc <= (phase_next == FETCH);
         o_dbus_cyc <= (phase_next == MEM);
         if (o_cnt_en) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   assign o_phase  = phase;
   assign o_cnt    = cnt;
   assign o_cnt_en = (phase == EXEC) || (phase == WBACK);
   // Instruction ends on any return to fetch
   assign o_pc_en  = (phase != FETCH) && (phase_next == FETCH);
   assign o_rd_en  = (phase == WBACK) || ((phase == EXEC) &&
                     ((i_opc == OPC_ALU_REG) || (i_opc == OPC_ALU_IMM) || (i_opc == OPC_LUI)));

   a_one_bus: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_ibus_cyc && o_dbus_cyc));

   // Each pass must finish a full wrap before the next fetch
   a_fetch_cnt: assert property (@(posedge clk) disable iff (!i_rst_n)
      ((phase != FETCH) && (phase_next == FETCH)) |=> (cnt == '0));

endmodule

// File: source/core_decode.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_decode
   import core_pkg::*;
   (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic [`CORE_XLEN-1:0] i_ibus_rdt,
   input  logic                  i_ibus_ack,
   input  logic                  i_cnt_en,
   output core_opc_e             o_opc,
   output core_aluop_e           o_aluop,
   output logic                  o_op_b_imm,
   output logic                  o_bne,
   output logic [4:0]            o_rd_addr,
   output logic [4:0]            o_rs1_addr,
   output logic [4:0]            o_rs2_addr,
   output logic                  o_imm,
   output logic                  o_dbus_we
   );

   logic [`CORE_XLEN-1:0] insn;
   logic [`CORE_XLEN-1:0] imm_sr;
   logic [`CORE_XLEN-1:0] imm_new;
   logic [2:0]            funct3;
   logic [6:0]            funct7;
   logic                  alu_f3;
   logic                  reg_ok;

   // All-zero word decodes as a no-op
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         insn <= '0;
      end else if (i_ibus_ack) begin
         insn <= i_ibus_rdt;
      end
   end

   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];
   // ADD/SUB, XOR, OR, AND
   assign alu_f3 = (funct3 == 3'b000) || (funct3[2] && (funct3 != 3'b101));
   assign reg_ok = (funct7 == 7'b0000000) || ((funct7 == 7'b0100000) && (funct3 == 3'b000));

   always_comb begin
      case (insn[6:0])
         7'b0110011: o_opc = (alu_f3 && reg_ok) ? OPC_ALU_REG : OPC_NOP;
         7'b0010011: o_opc = alu_f3 ? OPC_ALU_IMM : OPC_NOP;
         7'b0110111: o_opc = OPC_LUI;
         7'b0000011: o_opc = (funct3 == 3'b010) ? OPC_LOAD : OPC_NOP;
         7'b0100011: o_opc = (funct3 == 3'b010) ? OPC_STORE : OPC_NOP;
         7'b1100011: o_opc = (funct3[2:1] == 2'b00) ? OPC_BRANCH : OPC_NOP;
         default:    o_opc = OPC_NOP;
      endcase
   end

   always_comb begin
      case (funct3)
         3'b100:  o_aluop = ALU_XOR;
         3'b110:  o_aluop = ALU_OR;
         3'b111:  o_aluop = ALU_AND;
         default: o_aluop = ((o_opc == OPC_ALU_REG) && insn[30]) ? ALU_SUB : ALU_ADD;
      endcase
      if (o_opc == OPC_LUI) begin
         o_aluop = ALU_PASS_B;
      end
   end

   // Immediate is picked from the incoming word before the latch loads
   always_comb begin
      case (i_ibus_rdt[6:2])
         5'b01000: imm_new = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:25], i_ibus_rdt[11:7]};
         5'b11000: imm_new = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[7], i_ibus_rdt[30:25],
                              i_ibus_rdt[11:8], 1'b0};
         5'b01101: imm_new = {i_ibus_rdt[31:12], 12'b0};
         default:  imm_new = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_sr <= imm_new;
      end else if (i_cnt_en) begin
         imm_sr <= {imm_sr[`CORE_XLEN-1], imm_sr[`CORE_XLEN-1:1]};
      end
   end

   assign o_imm      = imm_sr[0];
   assign o_op_b_imm = (o_opc == OPC_ALU_IMM) || (o_opc == OPC_LUI);
   assign o_bne      = funct3[0];
   assign o_rd_addr  = insn[11:7];
   assign o_rs1_addr = insn[19:15];
   assign o_rs2_addr = insn[24:20];
   assign o_dbus_we  = (o_opc == OPC_STORE);

   // Shifter reloads only between passes
   a_imm_load: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus_ack |-> !i_cnt_en);

endmodule

// File: source/core_alu.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_alu
   import core_pkg::*;
   (
   input  logic                   clk,
   input  logic                   i_cnt_en,
   input  logic [`CORE_CNT_W-1:0] i_cnt,
   input  core_aluop_e            i_aluop,
   input  logic                   i_op_b_imm,
   input  logic                   i_rs1,
   input  logic                   i_rs2,
   input  logic                   i_imm,
   output logic                   o_rd,
   output logic                   o_eq
   );

   logic first;
   logic sub;
   logic op_b;
   logic b_in;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic eq_q;

   assign first    = (i_cnt == '0);
   assign sub      = (i_aluop == ALU_SUB);
   assign op_b     = i_op_b_imm ? i_imm : i_rs2;
   assign b_in     = op_b ^ sub;
   // Preset carry supplies the +1 of the two's complement
   assign carry_in = first ? sub : carry_q;
   assign sum      = i_rs1 ^ b_in ^ carry_in;
   // Includes the current bit, so it is complete during the last count
   assign o_eq     = (first || eq_q) && (i_rs1 == op_b);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= (i_rs1 & b_in) | (carry_in & (i_rs1 ^ b_in));
         eq_q    <= o_eq;
      end
   end

   always_comb begin
      case (i_aluop)
         ALU_ADD, ALU_SUB: o_rd = sum;
         ALU_AND:          o_rd = i_rs1 & op_b;
         ALU_OR:           o_rd = i_rs1 | op_b;
         ALU_XOR:          o_rd = i_rs1 ^ op_b;
         default:          o_rd = op_b;
      endcase
   end

endmodule

// File: source/core_rf.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_rf
   import core_pkg::*;
   (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic [`CORE_CNT_W-1:0] i_cnt,
   input  logic [4:0]             i_rs1_addr,
   input  logic [4:0]             i_rs2_addr,
   input  logic [4:0]             i_rd_addr,
   input  logic                   i_rd_en,
   input  core_state_e            i_phase,
   input  logic                   i_alu_rd,
   input  logic                   i_mem_rd,
   output logic                   o_rs1,
   output logic                   o_rs2
   );

   logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
   logic                  wr_bit;

   // Load data arrives during writeback, everything else from the ALU
   assign wr_bit = (i_phase == WBACK) ? i_mem_rd : i_alu_rd;

   // Bit i is read before it is written on the same edge
   assign o_rs1 = regs[i_rs1_addr][i_cnt];
   assign o_rs2 = regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < `CORE_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_en && (i_rd_addr != '0)) begin
         regs[i_rd_addr][i_cnt] <= wr_bit;
      end
   end

   // x0 stays zero even when an instruction names it as rd
   a_x0_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_rd_en && (i_rd_addr == '0)) |=> (regs[0] == '0));

endmodule

// File: source/core_ctrl.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_ctrl
   import core_pkg::*;
   (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_cnt_en,
   input  logic                  i_imm,
   input  logic                  i_pc_en,
   input  core_opc_e             i_opc,
   input  logic                  i_bne,
   input  logic                  i_eq,
   output logic [`CORE_XLEN-1:0] o_ibus_adr
   );

   logic [`CORE_XLEN-1:0] pc;
   logic [`CORE_XLEN-1:0] tgt;
   logic [`CORE_XLEN-1:0] pc_next;
   logic                  carry;
   logic                  sum;
   logic                  taken;

   // Target starts as a copy of the PC and rotates into PC plus immediate
   assign sum     = tgt[0] ^ i_imm ^ carry;
   assign taken   = (i_opc == OPC_BRANCH) && (i_eq != i_bne);
   // Top target bit is still on the adder when a branch ends
   assign pc_next = taken ? {sum, tgt[`CORE_XLEN-1:1]} : pc + 4;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc    <= `CORE_RESET_PC;
         tgt   <= `CORE_RESET_PC;
         carry <= 1'b0;
      end else if (i_pc_en) begin
         pc    <= pc_next;
         tgt   <= pc_next;
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         tgt   <= {sum, tgt[`CORE_XLEN-1:1]};
         carry <= (tgt[0] & i_imm) | (carry & (tgt[0] ^ i_imm));
      end
   end

   assign o_ibus_adr = pc;

endmodule

// File: source/core_mem_if.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_mem_if
   import core_pkg::*;
   (
   input  logic                  clk,
   input  logic                  i_rst_n,
   input  logic                  i_cnt_en,
   input  core_state_e           i_phase,
   input  logic                  i_rs1,
   input  logic                  i_rs2,
   input  logic                  i_imm,
   input  logic [`CORE_XLEN-1:0] i_dbus_rdt,
   input  logic                  i_dbus_ack,
   output logic [`CORE_XLEN-1:0] o_dbus_adr,
   output logic [`CORE_XLEN-1:0] o_dbus_dat,
   output logic                  o_rd
   );

   logic [`CORE_XLEN-1:0] adr;
   logic [`CORE_XLEN-1:0] dat;
   logic [`CORE_XLEN-1:0] rdat;
   logic                  exec_en;
   logic                  carry;
   logic                  sum;

   assign exec_en = i_cnt_en && (i_phase == EXEC);
   assign sum     = i_rs1 ^ i_imm ^ carry;

   // Carry clears in every phase outside execute
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else begin
         carry <= exec_en && ((i_rs1 & i_imm) | (carry & (i_rs1 ^ i_imm)));
      end
   end

   always_ff @(posedge clk) begin
      if (exec_en) begin
         adr <= {sum, adr[`CORE_XLEN-1:1]};
         dat <= {i_rs2, dat[`CORE_XLEN-1:1]};
      end
      if (i_dbus_ack && (i_phase == MEM)) begin
         rdat <= i_dbus_rdt;
      end else if (i_cnt_en && (i_phase == WBACK)) begin
         rdat <= {1'b0, rdat[`CORE_XLEN-1:1]};
      end
   end

   assign o_dbus_adr = adr;
   assign o_dbus_dat = dat;
   assign o_rd       = rdat[0];

endmodule

// File: source/core_top.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_top
   import core_pkg::*;
   (
   input  logic                  clk,
   input  logic                  i_rst_n,
   output logic [`CORE_XLEN-1:0] o_ibus_adr,
   output logic                  o_ibus_cyc,
   input  logic [`CORE_XLEN-1:0] i_ibus_rdt,
   input  logic                  i_ibus_ack,
   output logic [`CORE_XLEN-1:0] o_dbus_adr,
   output logic [`CORE_XLEN-1:0] o_dbus_dat,
   output logic                  o_dbus_we,
   output logic                  o_dbus_cyc,
   input  logic [`CORE_XLEN-1:0] i_dbus_rdt,
   input  logic                  i_dbus_ack
   );

   core_state_e            phase;
   core_opc_e              opc;
   core_aluop_e            aluop;
   logic [`CORE_CNT_W-1:0] cnt;
   logic                   cnt_en;
   logic                   pc_en;
   logic                   rd_en;
   logic                   op_b_imm;
   logic                   bne;
   logic [4:0]             rd_addr;
   logic [4:0]             rs1_addr;
   logic [4:0]             rs2_addr;
   logic                   imm;
   logic                   rs1;
   logic                   rs2;
   logic                   alu_rd;
   logic                   mem_rd;
   logic                   eq;

   core_state state0 (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_opc      (opc),
      .o_phase    (phase),
      .o_cnt      (cnt),
      .o_cnt_en   (cnt_en),
      .o_pc_en    (pc_en),
      .o_rd_en    (rd_en),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc)
   );

   core_decode decode0 (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt_en   (cnt_en),
      .o_opc      (opc),
      .o_aluop    (aluop),
      .o_op_b_imm (op_b_imm),
      .o_bne      (bne),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_imm      (imm),
      .o_dbus_we  (o_dbus_we)
   );

   core_alu alu0 (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_aluop    (aluop),
      .i_op_b_imm (op_b_imm),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .o_rd       (alu_rd),
      .o_eq       (eq)
   );

   core_rf rf0 (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_phase    (phase),
      .i_alu_rd   (alu_rd),
      .i_mem_rd   (mem_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   core_ctrl ctrl0 (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_imm      (imm),
      .i_pc_en    (pc_en),
      .i_opc      (opc),
      .i_bne      (bne),
      .i_eq       (eq),
      .o_ibus_adr (o_ibus_adr)
   );

   core_mem_if mem_if0 (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_phase    (phase),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_rd       (mem_rd)
   );

endmodule

// File: test/core_tb.sv
`timescale 1ns/10ps

`include "core_consts.svh"

module core_tb;

   localparam int          MEM_WORDS  = 1024;
   localparam int          QUIET_END  = 200;
   localparam logic [16:0] LFSR_SEED  = 17'd73085;
   localparam string       IMAGE_FILE = "test/core_stimulus.txt";

   logic                  clk;
   logic                  rst_n;
   logic [`CORE_XLEN-1:0] ibus_adr;
   logic                  ibus_cyc;
   logic [`CORE_XLEN-1:0] ibus_rdt;
   logic                  ibus_ack;
   logic [`CORE_XLEN-1:0] dbus_adr;
   logic [`CORE_XLEN-1:0] dbus_dat;
   logic                  dbus_we;
   logic                  dbus_cyc;
   logic [`CORE_XLEN-1:0] dbus_rdt;
   logic                  dbus_ack;

   logic [31:0] mem [MEM_WORDS];
   logic        loaded [MEM_WORDS];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   logic [16:0] lfsr;
   int          errors;
   int          cycles;
   int          prog_words;
   int          store_idx;
   logic        first_fetch;
   logic        ibus_busy;
   int          ibus_wait;
   logic [31:0] ibus_hold;
   logic [31:0] last_fetch_adr;
   logic [31:0] last_fetch_word;
   logic        dbus_busy;
   int          dbus_wait;
   logic [31:0] dbus_adr_hold;
   logic [31:0] dbus_dat_hold;
   logic        dbus_we_hold;

   core_top dut0 (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   always #10 clk = ~clk;

   // Taps 17 and 14
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   function automatic int word_of(input logic [31:0] adr);
      return int'(adr[11:2]);
   endfunction

   // BEQ or BNE
   function automatic logic is_branch(input logic [31:0] w);
      return (w[6:0] == 7'b1100011) && (w[14:13] == 2'b00);
   endfunction

   // B-type offset is a signed 13-bit byte count
   function automatic logic [31:0] branch_target(input logic [31:0] adr,
                                                 input logic [31:0] w);
      logic signed [12:0] off;
      off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
      return adr + 32'(off);
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   // Next fetch is PC plus 4 or the target after a branch
   task automatic verify_fetch_order();
      logic [31:0] exp;
      logic [31:0] tgt;
      exp = last_fetch_adr + 32'd4;
      tgt = branch_target(last_fetch_adr, last_fetch_word);
      if (is_branch(last_fetch_word) && (ibus_adr == tgt)) begin
         exp = tgt;
      end
      check_val("o_ibus_adr", ibus_adr, exp);
   endtask

   // Acknowledge delay of 0 to 3 cycles
   task automatic pick_delay(output int d);
      d = 0;
      for (int k = 0; k < 2; k++) begin
         lfsr = lfsr_next(lfsr);
         d = (d << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic read_image();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  tag;
      logic [31:0] a;
      logic [31:0] d;
      fd = $fopen(IMAGE_FILE, "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open the image file %s", IMAGE_FILE);
         return;
      end
      while ($fgets(line, fd) > 0) begin
         n = $sscanf(line, "%c %h %h", tag, a, d);
         if ((n == 3) && (tag == "P")) begin
            mem[word_of(a)]    = d;
            loaded[word_of(a)] = 1'b1;
            prog_words++;
         end else if ((n == 3) && (tag == "S")) begin
            exp_adr.push_back(a);
            exp_dat.push_back(d);
         end
      end
      $fclose(fd);
      if (exp_adr.size() == 0) begin
         errors++;
         $display("The image file holds no expected stores");
      end
   endtask

   task automatic serve_ibus();
      if (ibus_ack) begin
         ibus_ack  = 1'b0;
         ibus_rdt  = '0;
         ibus_busy = 1'b0;
         check_val("o_ibus_cyc", 32'(ibus_cyc), 32'd0);
      end else if (ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy = 1'b1;
            ibus_hold = ibus_adr;
            pick_delay(ibus_wait);
            if (first_fetch) begin
               check_val("o_ibus_adr", ibus_adr, `CORE_RESET_PC);
               first_fetch = 1'b0;
            end else begin
               verify_fetch_order();
            end
            if ((ibus_adr[1:0] != 2'b00) || (ibus_adr[31:12] != '0) ||
                !loaded[word_of(ibus_adr)]) begin
               errors++;
               $display("Fetch from 0x%h lies outside the program image", ibus_adr);
            end
         end else begin
            check_val("o_ibus_adr", ibus_adr, ibus_hold);
         end
         if (ibus_wait == 0) begin
            ibus_ack        = 1'b1;
            ibus_rdt        = mem[word_of(ibus_hold)];
            last_fetch_adr  = ibus_hold;
            last_fetch_word = ibus_rdt;
         end else begin
            ibus_wait--;
         end
      end else if (ibus_busy) begin
         errors++;
         ibus_busy = 1'b0;
         $display("Instruction bus cycle dropped before its acknowledge at %0t", $time);
      end
   endtask

   task automatic record_store();
      if (store_idx >= exp_adr.size()) begin
         errors++;
         $display("Unexpected store of 0x%h to 0x%h after the last expected store",
                  dbus_dat, dbus_adr);
      end else begin
         check_val("o_dbus_adr", dbus_adr, exp_adr[store_idx]);
         check_val("o_dbus_dat", dbus_dat, exp_dat[store_idx]);
         store_idx++;
      end
      mem[word_of(dbus_adr)] = dbus_dat;
   endtask

   task automatic serve_dbus();
      if (dbus_ack) begin
         dbus_ack  = 1'b0;
         dbus_rdt  = '0;
         dbus_busy = 1'b0;
         check_val("o_dbus_cyc", 32'(dbus_cyc), 32'd0);
      end else if (dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy     = 1'b1;
            dbus_adr_hold = dbus_adr;
            dbus_dat_hold = dbus_dat;
            dbus_we_hold  = dbus_we;
            pick_delay(dbus_wait);
            if (dbus_we) begin
               record_store();
            end
         end else begin
            check_val("o_dbus_adr", dbus_adr, dbus_adr_hold);
            check_val("o_dbus_we", 32'(dbus_we), 32'(dbus_we_hold));
            if (dbus_we_hold) begin
               check_val("o_dbus_dat", dbus_dat, dbus_dat_hold);
            end
         end
         if (dbus_wait == 0) begin
            dbus_ack = 1'b1;
            if (!dbus_we_hold) begin
               dbus_rdt = mem[word_of(dbus_adr_hold)];
            end
         end else begin
            dbus_wait--;
         end
      end else if (dbus_busy) begin
         errors++;
         dbus_busy = 1'b0;
         $display("Data bus cycle dropped before its acknowledge at %0t", $time);
      end
   endtask

   initial begin
      int   limit;
      int   quiet;
      logic finished;
      clk             = 1'b0;
      rst_n           = 1'b0;
      ibus_rdt        = '0;
      ibus_ack        = 1'b0;
      dbus_rdt        = '0;
      dbus_ack        = 1'b0;
      lfsr            = LFSR_SEED;
      errors          = 0;
      cycles          = 0;
      prog_words      = 0;
      store_idx       = 0;
      first_fetch     = 1'b1;
      ibus_busy       = 1'b0;
      ibus_wait       = 0;
      ibus_hold       = '0;
      last_fetch_adr  = '0;
      last_fetch_word = '0;
      dbus_busy       = 1'b0;
      dbus_wait       = 0;
      dbus_adr_hold   = '0;
      dbus_dat_hold   = '0;
      dbus_we_hold    = 1'b0;
      quiet           = 0;
      finished        = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]    = 32'hdead_0000 | 32'(i << 2);
         loaded[i] = 1'b0;
      end
      read_image();
      limit = 150 * prog_words + 40 * exp_adr.size();

      // Bus strobes stay idle through reset
      repeat (3) begin
         @(posedge clk);
         #1;
         check_val("o_ibus_cyc", 32'(ibus_cyc), 32'd0);
         check_val("o_dbus_cyc", 32'(dbus_cyc), 32'd0);
         check_val("o_dbus_we", 32'(dbus_we), 32'd0);
      end
      rst_n = 1'b1;

      while (!finished && (cycles < limit)) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles == 1) begin
            check_val("o_ibus_cyc", 32'(ibus_cyc), 32'd1);
            check_val("o_dbus_cyc", 32'(dbus_cyc), 32'd0);
            check_val("o_dbus_we", 32'(dbus_we), 32'd0);
         end
         serve_ibus();
         serve_dbus();
         // Quiet tail once every store is matched
         if (store_idx == exp_adr.size()) begin
            quiet++;
         end
         finished = (quiet >= QUIET_END);
      end

      if (!finished) begin
         errors++;
         $display("Timeout after %0d cycles with %0d of %0d stores seen",
                  cycles, store_idx, exp_adr.size());
      end
      $display("Errors: %0d, stores matched: %0d of %0d, cycles: %0d",
               errors, store_idx, exp_adr.size(), cycles);
      if (finished && (errors == 0)) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: test/core_stimulus.txt
# P <byte address> <word>    memory image, program then data
# S <byte address> <data>    expected stores, in program order
P 00000000 12300093  # addi x1, x0, 0x123
P 00000004 12345137  # lui  x2, 0x12345
P 00000008 002081B3  # add  x3, x1, x2
P 0000000C 10302023  # sw   x3, 0x100(x0)
P 00000010 40208233  # sub  x4, x1, x2
P 00000014 FFF24293  # xori x5, x4, -1
P 00000018 0051F333  # and  x6, x3, x5
P 0000001C 00136333  # or   x6, x6, x1
P 00000020 10602223  # sw   x6, 0x104(x0)
P 00000024 0041C3B3  # xor  x7, x3, x4
P 00000028 5553E393  # ori  x7, x7, 0x555
P 0000002C FF03F393  # andi x7, x7, -16
P 00000030 10702423  # sw   x7, 0x108(x0)
P 00000034 00508013  # addi x0, x1, 5
P 00000038 14002403  # lw   x8, 0x140(x0)
P 0000003C 10802623  # sw   x8, 0x10c(x0)
P 00000040 00208463  # beq  x1, x2, +8   not taken
P 00000044 10002823  # sw   x0, 0x110(x0)
P 00000048 00209463  # bne  x1, x2, +8   taken
P 0000004C 10102A23  # sw   x1, 0x114(x0)   skipped
P 00000050 00409493  # slli x9, x1, 4   unsupported
P 00000054 10902A23  # sw   x9, 0x114(x0)
P 00000058 00318463  # beq  x3, x3, +8   taken
P 0000005C 10302C23  # sw   x3, 0x118(x0)   skipped
P 00000060 00001463  # bne  x0, x0, +8   not taken
P 00000064 10402C23  # sw   x4, 0x118(x0)
P 00000068 00000063  # beq  x0, x0, 0   end loop
P 00000140 CAFEF00D  # load data
S 00000100 12345123
S 00000104 12344123
S 00000108 FFFFE550
S 0000010C CAFEF00D
S 00000110 00000000
S 00000114 00000000
S 00000118 EDCBB123

// File: filelist.f
+incdir+source
source/core_pkg.sv
source/core_state.sv
source/core_decode.sv
source/core_alu.sv
source/core_rf.sv
source/core_ctrl.sv
source/core_mem_if.sv
source/core_top.sv
test/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
